// File: rtl/sysarr_pkg.sv
package sysarr_pkg;

    // Default array sizes
    localparam int DEF_N = 4;
    localparam int DEF_WIDTH = 8;
    localparam int DEF_ACC_WIDTH = 24;

    // Control unit sequencing
    typedef enum logic [1:0] {
        IDLE,
        FEED,
        DRAIN
    } cu_state_t;

    // Width of a row index for an n-row array, never below one bit
    function automatic int row_idx_w(input int n);
        int w;
        if (n > 1) begin
            w = $clog2(n);
        end else begin
            w = 1;
        end
        return w;
    endfunction

endpackage

// File: rtl/sysarr_ifs.sv
// Control unit to datapath link
interface sysarr_cu_if #(
    parameter int N = sysarr_pkg::DEF_N
);
    localparam int RW = sysarr_pkg::row_idx_w(N);

    // Driven by the datapath
    logic input_load;
    logic partial_load;
    logic [RW-1:0] input_row;
    logic [RW-1:0] partial_row;

    // Driven by the control unit
    logic fifo_has_space;
    logic [N-1:0] in_shift;
    logic ps_shift;
    logic mac_shift;
    logic out_valid;
    logic [RW-1:0] out_row;
    logic busy;
    sysarr_pkg::cu_state_t state;

    modport control_unit (
        input input_load, partial_load, input_row, partial_row,
        output fifo_has_space, in_shift, ps_shift, mac_shift,
        output out_valid, out_row, busy, state
    );

    modport datapath (
        output input_load, partial_load, input_row, partial_row,
        input fifo_has_space, in_shift, ps_shift, mac_shift,
        input out_valid, out_row, busy, state
    );
endinterface

// One skew FIFO and its user
interface sysarr_fifo_if #(
    parameter int N = sysarr_pkg::DEF_N,
    parameter type elem_t = logic [sysarr_pkg::DEF_WIDTH-1:0]
);
    // Per-slot write enables, slot r holds matrix row r
    logic [N-1:0] load;
    logic shift;
    elem_t load_values [N];
    elem_t out;

    modport fifo (
        input load, shift, load_values,
        output out
    );

    modport user (
        output load, shift, load_values,
        input out
    );
endinterface

// File: rtl/sysarr_control_unit.sv
module sysarr_control_unit #(
    parameter int N = sysarr_pkg::DEF_N
)(
    input logic clk,
    input logic nRST,
    sysarr_cu_if.control_unit cu
);
    // Phase runs 0 .. 3N-1 over FEED and DRAIN
    localparam int PH_W = $clog2(3 * N);
    localparam int RW = sysarr_pkg::row_idx_w(N);
    localparam int FEED_LAST = 2 * N - 2;
    localparam int DRAIN_LAST = 3 * N - 1;
    localparam int OUT_FIRST = 2 * N;

    sysarr_pkg::cu_state_t state;
    logic [PH_W-1:0] phase;
    logic [N-1:0] in_mask;
    logic [N-1:0] ps_mask;
    logic all_loaded;

    assign all_loaded = (&in_mask) && (&ps_mask);

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state <= sysarr_pkg::IDLE;
            phase <= '0;
            in_mask <= '0;
            ps_mask <= '0;
        end else begin
            case (state)
                sysarr_pkg::IDLE: begin
                    if (all_loaded) begin
                        state <= sysarr_pkg::FEED;
                        in_mask <= '0;
                        ps_mask <= '0;
                    end else begin
                        // Rewriting a row sets the same bit again
                        if (cu.input_load) begin
                            in_mask[cu.input_row] <= 1'b1;
                        end
                        if (cu.partial_load) begin
                            ps_mask[cu.partial_row] <= 1'b1;
                        end
                    end
                end
                sysarr_pkg::FEED: begin
                    phase <= phase + 1'b1;
                    if (int'(phase) == FEED_LAST) begin
                        state <= sysarr_pkg::DRAIN;
                    end
                end
                sysarr_pkg::DRAIN: begin
                    if (int'(phase) == DRAIN_LAST) begin
                        state <= sysarr_pkg::IDLE;
                        phase <= '0;
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                default: begin
                    state <= sysarr_pkg::IDLE;
                    phase <= '0;
                end
            endcase
        end
    end

    assign cu.state = state;
    assign cu.busy = (state != sysarr_pkg::IDLE);
    assign cu.fifo_has_space = (state == sysarr_pkg::IDLE);

    // PEs and deskew lines move every cycle of a run
    assign cu.mac_shift = (state != sysarr_pkg::IDLE);

    // Input column k starts k cycles into FEED and empties N cycles later
    always_comb begin
        for (int k = 0; k < N; k++) begin
            cu.in_shift[k] = (state == sysarr_pkg::FEED)
                && (int'(phase) >= k) && (int'(phase) < k + N);
        end
    end

    // Partial row r is at the FIFO head one cycle before its result
    assign cu.ps_shift = (state == sysarr_pkg::DRAIN) && (int'(phase) != DRAIN_LAST);

    // First DRAIN cycle is a gap while the last adds settle
    assign cu.out_valid = (state == sysarr_pkg::DRAIN) && (int'(phase) >= OUT_FIRST);
    assign cu.out_row = RW'(int'(phase) - OUT_FIRST);

endmodule

// File: rtl/sysarr_fifo.sv
module sysarr_fifo #(
    parameter int N = sysarr_pkg::DEF_N,
    parameter type elem_t = logic [sysarr_pkg::DEF_WIDTH-1:0]
)(
    input logic clk,
    input logic nRST,
    sysarr_fifo_if.fifo fifo
);
    elem_t slots [N];
    elem_t shifted [N];

    // Head leaves, everything moves one slot forward, zero enters at the tail
    always_comb begin
        for (int i = 0; i < N - 1; i++) begin
            shifted[i] = slots[i + 1];
        end
        shifted[N - 1] = '0;
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < N; i++) begin
                slots[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                // A load wins over a shift on the same slot
                if (fifo.load[i]) begin
                    slots[i] <= fifo.load_values[i];
                end else if (fifo.shift) begin
                    slots[i] <= shifted[i];
                end
            end
        end
    end

    assign fifo.out = slots[0];

endmodule

// File: rtl/sysarr_mac.sv
module sysarr_mac #(
    parameter int WIDTH = sysarr_pkg::DEF_WIDTH,
    parameter int ACC_WIDTH = sysarr_pkg::DEF_ACC_WIDTH
)(
    input logic clk,
    input logic nRST,
    input logic shift,
    input logic [WIDTH-1:0] weight,
    input logic [WIDTH-1:0] in_value,
    input logic [ACC_WIDTH-1:0] in_accumulate,
    output logic [WIDTH-1:0] in_pass,
    output logic [ACC_WIDTH-1:0] out_accumulate
);
    logic [2*WIDTH-1:0] product;
    logic [ACC_WIDTH-1:0] sum;

    assign product = in_value * weight;

    // Wraps modulo 2^ACC_WIDTH
    assign sum = in_accumulate + ACC_WIDTH'(product);

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            in_pass <= '0;
            out_accumulate <= '0;
        end else if (shift) begin
            // Operand goes right, running sum goes down
            in_pass <= in_value;
            out_accumulate <= sum;
        end
    end

endmodule

// File: rtl/sysarr_out_stage.sv
module sysarr_out_stage #(
    parameter int N = sysarr_pkg::DEF_N,
    parameter int ACC_WIDTH = sysarr_pkg::DEF_ACC_WIDTH,
    parameter int COL = 0
)(
    input logic clk,
    input logic nRST,
    input logic shift,
    input logic [ACC_WIDTH-1:0] column_sum,
    input logic [ACC_WIDTH-1:0] partial,
    output logic [ACC_WIDTH-1:0] result
);
    // Column COL leaves the array COL cycles late, pad up to the last column
    localparam int DEPTH = N - 1 - COL;

    logic [ACC_WIDTH-1:0] delayed;

    if (DEPTH > 0) begin : g_delay
        logic [ACC_WIDTH-1:0] line [DEPTH];

        always_ff @(posedge clk, negedge nRST) begin
            if (!nRST) begin
                for (int i = 0; i < DEPTH; i++) begin
                    line[i] <= '0;
                end
            end else if (shift) begin
                line[0] <= column_sum;
                for (int i = 1; i < DEPTH; i++) begin
                    line[i] <= line[i - 1];
                end
            end
        end

        assign delayed = line[DEPTH - 1];
    end else begin : g_direct
        // Last column already lines up
        assign delayed = column_sum;
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            result <= '0;
        end else if (shift) begin
            result <= delayed + partial;
        end
    end

endmodule

// File: rtl/systolic_array.sv
module systolic_array #(
    parameter int N = sysarr_pkg::DEF_N,
    parameter int WIDTH = sysarr_pkg::DEF_WIDTH,
    parameter int ACC_WIDTH = sysarr_pkg::DEF_ACC_WIDTH
)(
    input logic clk,
    input logic nRST,
    input logic [WIDTH*N-1:0] array_in,
    input logic weight_en,
    input logic input_en,
    input logic [sysarr_pkg::row_idx_w(N)-1:0] row_in_en,
    input logic partial_en,
    input logic [sysarr_pkg::row_idx_w(N)-1:0] row_ps_en,
    input logic [ACC_WIDTH*N-1:0] array_in_partials,
    output logic fifo_has_space,
    output logic out_en,
    output logic [sysarr_pkg::row_idx_w(N)-1:0] row_out,
    output logic [ACC_WIDTH*N-1:0] array_output,
    output logic drained
);
    localparam int RW = sysarr_pkg::row_idx_w(N);

    typedef logic [WIDTH-1:0] op_t;
    typedef logic [ACC_WIDTH-1:0] acc_t;

    // Element 0 of every bus row sits in the most significant slot
    logic input_load;
    logic weight_load;
    logic partial_load;
    logic [N-1:0] loadi;
    logic [N-1:0] loadw;
    logic [N-1:0] loadps;
    logic [WIDTH*N-1:0] weights [N];
    op_t row_feed [N];
    acc_t ps_feed [N];
    op_t pe_pass [N][N];
    acc_t pe_acc [N][N];
    acc_t col_result [N];

    sysarr_cu_if #(.N(N)) cu_bus ();

    sysarr_control_unit #(.N(N)) u_cu (
        .clk(clk),
        .nRST(nRST),
        .cu(cu_bus.control_unit)
    );

    // Input write wins when both array_in enables are up
    assign input_load = input_en && cu_bus.fifo_has_space;
    assign weight_load = weight_en && !input_en && cu_bus.fifo_has_space;
    assign partial_load = partial_en && cu_bus.fifo_has_space;

    always_comb begin
        for (int i = 0; i < N; i++) begin
            loadi[i] = input_load && (row_in_en == RW'(i));
            loadw[i] = weight_load && (row_in_en == RW'(i));
            loadps[i] = partial_load && (row_ps_en == RW'(i));
        end
    end

    assign cu_bus.input_load = input_load;
    assign cu_bus.partial_load = partial_load;
    assign cu_bus.input_row = row_in_en;
    assign cu_bus.partial_row = row_ps_en;

    // Weights stay until rewritten
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < N; i++) begin
                weights[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                if (loadw[i]) begin
                    weights[i] <= array_in;
                end
            end
        end
    end

    // FIFO k collects column k of the input matrix and feeds PE row k
    for (genvar k = 0; k < N; k++) begin : g_in_fifo
        sysarr_fifo_if #(.N(N), .elem_t(op_t)) in_if ();

        sysarr_fifo #(.N(N), .elem_t(op_t)) u_fifo (
            .clk(clk),
            .nRST(nRST),
            .fifo(in_if.fifo)
        );

        assign in_if.load = loadi;
        assign in_if.shift = cu_bus.in_shift[k];
        for (genvar r = 0; r < N; r++) begin : g_val
            assign in_if.load_values[r] = array_in[(N-k)*WIDTH-1 -: WIDTH];
        end
        assign row_feed[k] = in_if.out;
    end

    // FIFO c collects column c of the addend matrix
    for (genvar c = 0; c < N; c++) begin : g_ps_fifo
        sysarr_fifo_if #(.N(N), .elem_t(acc_t)) ps_if ();

        sysarr_fifo #(.N(N), .elem_t(acc_t)) u_fifo (
            .clk(clk),
            .nRST(nRST),
            .fifo(ps_if.fifo)
        );

        assign ps_if.load = loadps;
        assign ps_if.shift = cu_bus.ps_shift;
        for (genvar r = 0; r < N; r++) begin : g_val
            assign ps_if.load_values[r] = array_in_partials[(N-c)*ACC_WIDTH-1 -: ACC_WIDTH];
        end
        assign ps_feed[c] = ps_if.out;
    end

    // PE[k][c] holds weight[k][c]
    for (genvar k = 0; k < N; k++) begin : g_row
        for (genvar c = 0; c < N; c++) begin : g_col
            op_t in_value;
            acc_t in_acc;

            if (c == 0) begin : g_left
                assign in_value = row_feed[k];
            end else begin : g_fwd
                assign in_value = pe_pass[k][c-1];
            end

            if (k == 0) begin : g_top
                assign in_acc = '0;
            end else begin : g_chain
                assign in_acc = pe_acc[k-1][c];
            end

            sysarr_mac #(.WIDTH(WIDTH), .ACC_WIDTH(ACC_WIDTH)) u_mac (
                .clk(clk),
                .nRST(nRST),
                .shift(cu_bus.mac_shift),
                .weight(weights[k][(N-c)*WIDTH-1 -: WIDTH]),
                .in_value(in_value),
                .in_accumulate(in_acc),
                .in_pass(pe_pass[k][c]),
                .out_accumulate(pe_acc[k][c])
            );
        end
    end

    for (genvar c = 0; c < N; c++) begin : g_out
        sysarr_out_stage #(.N(N), .ACC_WIDTH(ACC_WIDTH), .COL(c)) u_stage (
            .clk(clk),
            .nRST(nRST),
            .shift(cu_bus.mac_shift),
            .column_sum(pe_acc[N-1][c]),
            .partial(ps_feed[c]),
            .result(col_result[c])
        );
    end

    // One aligned result row per DRAIN output cycle
    always_comb begin
        array_output = '0;
        if (cu_bus.out_valid) begin
            for (int c = 0; c < N; c++) begin
                array_output[(N-c)*ACC_WIDTH-1 -: ACC_WIDTH] = col_result[c];
            end
        end
    end

    assign out_en = cu_bus.out_valid;
    assign row_out = cu_bus.out_row;
    assign fifo_has_space = cu_bus.fifo_has_space;
    assign drained = !cu_bus.busy;

endmodule

// File: tb/systolic_array_chk.sv
module systolic_array_chk #(
    parameter int N = sysarr_pkg::DEF_N
)(
    input logic clk,
    input logic nRST,
    input logic fifo_has_space,
    input logic out_en,
    input logic drained,
    input logic [sysarr_pkg::row_idx_w(N)-1:0] row_out,
    input sysarr_pkg::cu_state_t state
);
    // Results only leave a running array
    a_out_rise: assert property (@(posedge clk) disable iff (!nRST)
        $rose(out_en) |-> !fifo_has_space)
        else $error("out_en rose while fifo_has_space was high");

    a_drained_excl: assert property (@(posedge clk) disable iff (!nRST)
        !(drained && out_en))
        else $error("drained and out_en high together");

    // Rows come back in order, one per cycle
    a_row_step: assert property (@(posedge clk) disable iff (!nRST)
        (out_en && $past(out_en)) |-> (row_out == $past(row_out) + 1'b1))
        else $error("row_out did not step by one");

    a_reset_state: assert property (@(posedge clk)
        $rose(nRST) |-> (!out_en && fifo_has_space))
        else $error("out_en or fifo_has_space wrong after reset");

    // First result row a fixed time after FEED begins
    a_out_latency: assert property (@(posedge clk) disable iff (!nRST)
        $rose(out_en) |-> (($past(state, 2 * N) == sysarr_pkg::FEED)
            && ($past(state, 2 * N + 1) == sysarr_pkg::IDLE)))
        else $error("first out_en not 2N+1 cycles after entering FEED");

endmodule

bind systolic_array systolic_array_chk #(.N(N)) u_chk (
    .clk(clk),
    .nRST(nRST),
    .fifo_has_space(fifo_has_space),
    .out_en(out_en),
    .drained(drained),
    .row_out(row_out),
    .state(cu_bus.state)
);

// File: tb/systolic_array_tb.sv
module systolic_array_tb;
    localparam int N = sysarr_pkg::DEF_N;
    localparam int WIDTH = sysarr_pkg::DEF_WIDTH;
    localparam int ACC_WIDTH = sysarr_pkg::DEF_ACC_WIDTH;
    localparam int RW = sysarr_pkg::row_idx_w(N);
    localparam int TIMEOUT = 20 * N;
    localparam int COND_SPACE = 0;
    localparam int COND_OUT = 1;
    localparam int COND_ROWS = 2;
    localparam int COND_DRAINED = 3;

    typedef logic [ACC_WIDTH-1:0] acc_t;

    logic clk;
    logic nRST;
    logic [WIDTH*N-1:0] array_in;
    logic weight_en;
    logic input_en;
    logic [RW-1:0] row_in_en;
    logic partial_en;
    logic [RW-1:0] row_ps_en;
    logic [ACC_WIDTH*N-1:0] array_in_partials;
    logic fifo_has_space;
    logic out_en;
    logic [RW-1:0] row_out;
    logic [ACC_WIDTH*N-1:0] array_output;
    logic drained;

    // Matrices as last written, indexed [row][column]
    logic [WIDTH-1:0] w_mat [N][N];
    logic [WIDTH-1:0] in_mat [N][N];
    acc_t ps_mat [N][N];
    acc_t exp_rows [N][N];
    int seed = 32'hcd233bb6;
    int rows_done = 0;
    int expect_row = 0;
    string test_name = "reset";

    systolic_array uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input acc_t expected, input acc_t actual);
        if (expected !== actual) begin
            fail_run($sformatf("FAIL [%s] %s: expected %0h actual %0h",
                test_name, what, expected, actual));
        end
    endtask

    // Partial sum plus the row-by-column dot product, wrapping at ACC_WIDTH
    function automatic acc_t ref_elem(input int r, input int c);
        acc_t acc;
        logic [2*WIDTH-1:0] prod;
        acc = ps_mat[r][c];
        for (int k = 0; k < N; k++) begin
            prod = in_mat[r][k] * w_mat[k][c];
            acc = acc + ACC_WIDTH'(prod);
        end
        return acc;
    endfunction

    function automatic bit condition_met(input int what, input int target);
        case (what)
            COND_SPACE: return fifo_has_space;
            COND_OUT: return out_en;
            COND_ROWS: return rows_done >= target;
            default: return drained;
        endcase
    endfunction

    task automatic wait_for(input int what, input int target, input string msg);
        int t;
        t = 0;
        while (!condition_met(what, target)) begin
            @(posedge clk);
            #5;
            t++;
            if (t > TIMEOUT) begin
                fail_run(msg);
            end
        end
    endtask

    function automatic int scrambled(input int i);
        return (3 * i + 2) % N;
    endfunction

    task automatic fill_matrices(input bit weights, input bit max_ops, input bit zero_ps);
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                if (weights) begin
                    w_mat[r][c] = max_ops ? '1 : WIDTH'($random(seed));
                end
                in_mat[r][c] = max_ops ? '1 : WIDTH'($random(seed));
                if (zero_ps) begin
                    ps_mat[r][c] = '0;
                end else begin
                    // Low bit forced so every addend is nonzero
                    ps_mat[r][c] = max_ops ? '1 : (acc_t'($random(seed)) | acc_t'(1));
                end
            end
        end
    endtask

    // sel 0 weight row, 1 input row, 2 partial row; held for one cycle
    task automatic load_row(input int sel, input int r);
        wait_for(COND_SPACE, 0, "Timed out waiting for fifo_has_space before a load");
        for (int c = 0; c < N; c++) begin
            array_in[(N-c)*WIDTH-1 -: WIDTH] = (sel == 0) ? w_mat[r][c] : in_mat[r][c];
            array_in_partials[(N-c)*ACC_WIDTH-1 -: ACC_WIDTH] = ps_mat[r][c];
        end
        row_in_en = RW'(r);
        row_ps_en = RW'(r);
        weight_en = (sel == 0);
        input_en = (sel == 1);
        partial_en = (sel == 2);
        @(posedge clk);
        #5;
        weight_en = 1'b0;
        input_en = 1'b0;
        partial_en = 1'b0;
    endtask

    task automatic expect_results();
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                exp_rows[r][c] = ref_elem(r, c);
            end
        end
    endtask

    task automatic load_all(input bit with_weights);
        for (int sel = (with_weights ? 0 : 1); sel < 3; sel++) begin
            for (int r = 0; r < N; r++) begin
                load_row(sel, r);
            end
        end
        expect_results();
    endtask

    task automatic finish_run(input int base);
        wait_for(COND_ROWS, base + N, "Timed out waiting for the result rows");
        wait_for(COND_DRAINED, 0, "Timed out waiting for drained after a run");
        check_value("fifo_has_space after run", acc_t'(1), acc_t'(fifo_has_space));
    endtask

    // Compare every result row as it leaves the array
    always @(negedge clk) begin
        if (nRST) begin
            if (expect_row != 0) begin
                check_value("out_en held across rows", acc_t'(1), acc_t'(out_en));
            end
            if (out_en) begin
                check_value("row_out", acc_t'(expect_row), acc_t'(row_out));
                for (int c = 0; c < N; c++) begin
                    check_value($sformatf("row %0d col %0d", expect_row, c),
                        exp_rows[expect_row][c], array_output[(N-c)*ACC_WIDTH-1 -: ACC_WIDTH]);
                end
                expect_row = (expect_row == N - 1) ? 0 : expect_row + 1;
                rows_done++;
            end
        end
    end

    initial begin
        int base;
        nRST = 1'b0;
        array_in = '0;
        weight_en = 1'b0;
        input_en = 1'b0;
        row_in_en = '0;
        partial_en = 1'b0;
        row_ps_en = '0;
        array_in_partials = '0;
        repeat (16) @(posedge clk);
        #5;
        nRST = 1'b1;
        check_value("drained", acc_t'(1), acc_t'(drained));
        check_value("fifo_has_space", acc_t'(1), acc_t'(fifo_has_space));
        check_value("out_en", acc_t'(0), acc_t'(out_en));

        test_name = "plain product";
        fill_matrices(1'b1, 1'b0, 1'b1);
        base = rows_done;
        load_all(1'b1);
        finish_run(base);

        // Old weights reused with new inputs and addends
        test_name = "weights persist";
        fill_matrices(1'b0, 1'b0, 1'b0);
        base = rows_done;
        load_all(1'b0);
        finish_run(base);

        test_name = "wrap with max operands";
        fill_matrices(1'b1, 1'b1, 1'b0);
        base = rows_done;
        load_all(1'b1);
        finish_run(base);

        // Rows offered while results drain must be refused
        test_name = "loads during drain";
        fill_matrices(1'b0, 1'b0, 1'b0);
        base = rows_done;
        load_all(1'b0);
        wait_for(COND_OUT, 0, "Timed out waiting for the first result row");
        for (int i = 0; i < N - 1; i++) begin
            @(posedge clk);
            #5;
            array_in = ~array_in;
            array_in_partials = ~array_in_partials;
            row_in_en = RW'(i);
            row_ps_en = RW'(i);
            input_en = 1'b1;
            partial_en = 1'b1;
        end
        @(posedge clk);
        #5;
        input_en = 1'b0;
        partial_en = 1'b0;
        finish_run(base);

        test_name = "scrambled rows";
        fill_matrices(1'b1, 1'b0, 1'b0);
        base = rows_done;
        for (int i = 0; i < N; i++) begin
            load_row(0, scrambled(i));
        end
        for (int i = 0; i < N - 1; i++) begin
            load_row(1, scrambled(i));
        end
        // Rewrite the first row before the last new one
        for (int c = 0; c < N; c++) begin
            in_mat[scrambled(0)][c] = ~in_mat[scrambled(0)][c];
        end
        load_row(1, scrambled(0));
        load_row(1, scrambled(N - 1));
        for (int i = 0; i < N; i++) begin
            load_row(2, scrambled(i));
        end
        expect_results();
        finish_run(base);

        if (rows_done == 5 * N) begin
            $display(">>> PASS");
            $finish;
        end else begin
            fail_run($sformatf("Expected %0d result rows, saw %0d", 5 * N, rows_done));
        end
    end

endmodule

// File: systolic_array.f
rtl/sysarr_pkg.sv
rtl/sysarr_ifs.sv
rtl/sysarr_control_unit.sv
rtl/sysarr_fifo.sv
rtl/sysarr_mac.sv
rtl/sysarr_out_stage.sv
rtl/systolic_array.sv
tb/systolic_array_chk.sv
tb/systolic_array_tb.sv

// File: Makefile
# Verilator build and run of the systolic array testbench

VERILATOR ?= verilator
TOP ?= systolic_array_tb
FILELIST ?= systolic_array.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
